//--- design/isa_pkg.sv
package isa_pkg;

    // access width of a load
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // funct3 field of the LOAD opcode
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_funct3_e;

    typedef struct packed {
        mem_size_e size;
        logic      is_signed;
    } load_dec_t;

    function automatic load_dec_t load_decode(input logic [2:0] funct3);
        load_dec_t dec;
        dec.size      = WORD; // unlisted codes end up as signed word
        dec.is_signed = 1'b1;
        case (funct3)
            LB: begin
                dec.size = BYTE;
            end
            LH: begin
                dec.size = HALF;
            end
            LBU: begin
                dec.size      = BYTE;
                dec.is_signed = 1'b0;
            end
            LHU: begin
                dec.size      = HALF;
                dec.is_signed = 1'b0;
            end
            default: ;
        endcase
        return dec;
    endfunction

endpackage

//--- design/wb_pkg.sv
package wb_pkg;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned PRF_TAG_W = 7;  // 128 physical regs
    localparam int unsigned ROB_IDX_W = 6;  // 64 rob entries

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [PRF_TAG_W-1:0] prf_tag_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // one common data bus slot, 1 + 7 + 32 bits
    typedef struct packed {
        logic     valid;
        prf_tag_t phys_tag;
        xlen_t    value;
    } cdb_entry_t;

endpackage

//--- design/wb_lane_if.sv
interface wb_lane_if
    import wb_pkg::*;
#(
    parameter int unsigned LANES = 1
);

    logic     [LANES-1:0] valid;
    xlen_t    [LANES-1:0] value;
    prf_tag_t [LANES-1:0] dest;
    rob_idx_t [LANES-1:0] rob_idx;
    logic     [LANES-1:0] exception;
    logic     [LANES-1:0] mispred;

    modport producer (
        output valid,
        output value,
        output dest,
        output rob_idx,
        output exception,
        output mispred
    );

    modport consumer (
        input valid,
        input value,
        input dest,
        input rob_idx,
        input exception,
        input mispred
    );

endinterface

//--- design/fu_result_capture.sv
module fu_result_capture
    import wb_pkg::*;
#(
    parameter int unsigned WB_WIDTH = 4
) (
    input  logic                     clock,
    input  logic                     arst_n_i,
    input  logic     [WB_WIDTH-1:0]  fu_valid_i,
    input  xlen_t    [WB_WIDTH-1:0]  fu_value_i,
    input  xlen_t    [WB_WIDTH-1:0]  fu_link_i,
    input  logic     [WB_WIDTH-1:0]  fu_is_jump_i,
    input  prf_tag_t [WB_WIDTH-1:0]  fu_dest_i,
    input  rob_idx_t [WB_WIDTH-1:0]  fu_rob_idx_i,
    input  logic     [WB_WIDTH-1:0]  fu_exception_i,
    input  logic     [WB_WIDTH-1:0]  fu_mispred_i,
    wb_lane_if.producer              lanes
);

    logic     [WB_WIDTH-1:0] valid_q;
    xlen_t    [WB_WIDTH-1:0] value_q;
    prf_tag_t [WB_WIDTH-1:0] dest_q;
    rob_idx_t [WB_WIDTH-1:0] rob_idx_q;
    logic     [WB_WIDTH-1:0] exception_q;
    logic     [WB_WIDTH-1:0] mispred_q;

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= fu_valid_i;
        end
    end

    // payload only loads on a valid lane
    always_ff @(posedge clock) begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (fu_valid_i[i]) begin
                // jal/jalr write rd = pc + 4, not the target
                value_q[i]     <= fu_is_jump_i[i] ? fu_link_i[i] : fu_value_i[i];
                dest_q[i]      <= fu_dest_i[i];
                rob_idx_q[i]   <= fu_rob_idx_i[i];
                exception_q[i] <= fu_exception_i[i];
                mispred_q[i]   <= fu_mispred_i[i];
            end
        end
    end

    assign lanes.valid     = valid_q;
    assign lanes.value     = value_q;
    assign lanes.dest      = dest_q;
    assign lanes.rob_idx   = rob_idx_q;
    assign lanes.exception = exception_q;
    assign lanes.mispred   = mispred_q;

endmodule

//--- design/load_result_align.sv
module load_result_align
    import isa_pkg::*;
    import wb_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n_i,
    input  logic        ld_valid_i,
    output logic        ld_ready_o,
    input  xlen_t       ld_data_i,
    input  logic [1:0]  ld_addr_lo_i,
    input  logic [2:0]  ld_funct3_i,
    input  prf_tag_t    ld_dest_i,
    input  rob_idx_t    ld_rob_idx_i,
    input  logic        ld_drain_i,
    wb_lane_if.producer lane
);

    load_dec_t dec;
    xlen_t     shifted;
    xlen_t     aligned;
    logic      accept;
    logic      full_q;
    xlen_t     value_q;
    prf_tag_t  dest_q;
    rob_idx_t  rob_idx_q;

    assign dec     = load_decode(ld_funct3_i);
    assign shifted = ld_data_i >> {ld_addr_lo_i, 3'b000}; // byte offset to bit offset

    always_comb begin
        case (dec.size)
            BYTE: begin
                aligned = dec.is_signed ? {{(XLEN-8){shifted[7]}}, shifted[7:0]}
                                        : {{(XLEN-8){1'b0}}, shifted[7:0]};
            end
            HALF: begin
                aligned = dec.is_signed ? {{(XLEN-16){shifted[15]}}, shifted[15:0]}
                                        : {{(XLEN-16){1'b0}}, shifted[15:0]};
            end
            default: begin
                aligned = ld_data_i; // word, offset ignored
            end
        endcase
    end

    // one entry, refilled in the same cycle it drains
    assign ld_ready_o = !full_q || ld_drain_i;
    assign accept     = ld_valid_i && ld_ready_o;

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (ld_drain_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            value_q   <= aligned;
            dest_q    <= ld_dest_i;
            rob_idx_q <= ld_rob_idx_i;
        end
    end

    assign lane.valid[0]     = full_q;
    assign lane.value[0]     = value_q;
    assign lane.dest[0]      = dest_q;
    assign lane.rob_idx[0]   = rob_idx_q;
    assign lane.exception[0] = 1'b0; // faults are taken in the lsq
    assign lane.mispred[0]   = 1'b0;

endmodule

//--- design/complete_merge.sv
module complete_merge
    import wb_pkg::*;
#(
    parameter int unsigned WB_WIDTH  = 4,
    parameter int unsigned LOAD_LANE = 2
) (
    wb_lane_if.consumer                fu_lanes,
    wb_lane_if.consumer                ld_lane,
    output logic                       ld_drain_o,
    // physical register file
    output logic       [WB_WIDTH-1:0]  prf_wr_en_o,
    output prf_tag_t   [WB_WIDTH-1:0]  prf_waddr_o,
    output xlen_t      [WB_WIDTH-1:0]  prf_wdata_o,
    // rob completion
    output logic       [WB_WIDTH-1:0]  wb_valid_o,
    output rob_idx_t   [WB_WIDTH-1:0]  wb_rob_idx_o,
    output logic       [WB_WIDTH-1:0]  wb_exception_o,
    output logic       [WB_WIDTH-1:0]  wb_mispred_o,
    output xlen_t      [WB_WIDTH-1:0]  wb_value_o,
    // broadcast
    output cdb_entry_t [WB_WIDTH-1:0]  cdb_o
);

    logic     [WB_WIDTH-1:0] sel_valid;
    xlen_t    [WB_WIDTH-1:0] sel_value;
    prf_tag_t [WB_WIDTH-1:0] sel_dest;
    rob_idx_t [WB_WIDTH-1:0] sel_rob_idx;
    logic     [WB_WIDTH-1:0] sel_exception;
    logic     [WB_WIDTH-1:0] sel_mispred;

    // fu has priority on the shared lane
    assign ld_drain_o = ld_lane.valid[0] && !fu_lanes.valid[LOAD_LANE];

    always_comb begin
        sel_valid     = fu_lanes.valid;
        sel_value     = fu_lanes.value;
        sel_dest      = fu_lanes.dest;
        sel_rob_idx   = fu_lanes.rob_idx;
        sel_exception = fu_lanes.exception;
        sel_mispred   = fu_lanes.mispred;
        if (ld_drain_o) begin
            sel_valid[LOAD_LANE]     = 1'b1;
            sel_value[LOAD_LANE]     = ld_lane.value[0];
            sel_dest[LOAD_LANE]      = ld_lane.dest[0];
            sel_rob_idx[LOAD_LANE]   = ld_lane.rob_idx[0];
            sel_exception[LOAD_LANE] = ld_lane.exception[0];
            sel_mispred[LOAD_LANE]   = ld_lane.mispred[0];
        end
    end

    // idle lanes drive zeros, keeps stale payload off the buses
    always_comb begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            prf_wr_en_o[i]    = sel_valid[i];
            prf_waddr_o[i]    = sel_valid[i] ? sel_dest[i] : '0;
            prf_wdata_o[i]    = sel_valid[i] ? sel_value[i] : '0;

            wb_valid_o[i]     = sel_valid[i];
            wb_rob_idx_o[i]   = sel_valid[i] ? sel_rob_idx[i] : '0;
            wb_exception_o[i] = sel_valid[i] && sel_exception[i];
            wb_mispred_o[i]   = sel_valid[i] && sel_mispred[i];
            wb_value_o[i]     = prf_wdata_o[i];

            cdb_o[i].valid    = sel_valid[i];
            cdb_o[i].phys_tag = prf_waddr_o[i];
            cdb_o[i].value    = prf_wdata_o[i];
        end
    end

endmodule

//--- design/complete_unit.sv
module complete_unit
    import wb_pkg::*;
#(
    parameter int unsigned WB_WIDTH  = 4,
    parameter int unsigned LOAD_LANE = 2 // must be < WB_WIDTH
) (
    input  logic                       clock,
    input  logic                       arst_n_i,
    // functional units
    input  logic       [WB_WIDTH-1:0]  fu_valid_i,
    input  xlen_t      [WB_WIDTH-1:0]  fu_value_i,
    input  xlen_t      [WB_WIDTH-1:0]  fu_link_i,
    input  logic       [WB_WIDTH-1:0]  fu_is_jump_i,
    input  prf_tag_t   [WB_WIDTH-1:0]  fu_dest_i,
    input  rob_idx_t   [WB_WIDTH-1:0]  fu_rob_idx_i,
    input  logic       [WB_WIDTH-1:0]  fu_exception_i,
    input  logic       [WB_WIDTH-1:0]  fu_mispred_i,
    // load from lsq
    input  logic                       ld_valid_i,
    output logic                       ld_ready_o,
    input  xlen_t                      ld_data_i,
    input  logic       [1:0]           ld_addr_lo_i,
    input  logic       [2:0]           ld_funct3_i,
    input  prf_tag_t                   ld_dest_i,
    input  rob_idx_t                   ld_rob_idx_i,
    // prf write
    output logic       [WB_WIDTH-1:0]  prf_wr_en_o,
    output prf_tag_t   [WB_WIDTH-1:0]  prf_waddr_o,
    output xlen_t      [WB_WIDTH-1:0]  prf_wdata_o,
    // rob
    output logic       [WB_WIDTH-1:0]  wb_valid_o,
    output rob_idx_t   [WB_WIDTH-1:0]  wb_rob_idx_o,
    output logic       [WB_WIDTH-1:0]  wb_exception_o,
    output logic       [WB_WIDTH-1:0]  wb_mispred_o,
    output xlen_t      [WB_WIDTH-1:0]  wb_value_o,
    // cdb
    output cdb_entry_t [WB_WIDTH-1:0]  cdb_o
);

    logic ld_drain;

    wb_lane_if #(.LANES(WB_WIDTH)) fu_lanes ();
    wb_lane_if #(.LANES(1))        ld_lane ();

    fu_result_capture #(
        .WB_WIDTH (WB_WIDTH)
    ) u_fu_capture (
        .clock          (clock),
        .arst_n_i       (arst_n_i),
        .fu_valid_i     (fu_valid_i),
        .fu_value_i     (fu_value_i),
        .fu_link_i      (fu_link_i),
        .fu_is_jump_i   (fu_is_jump_i),
        .fu_dest_i      (fu_dest_i),
        .fu_rob_idx_i   (fu_rob_idx_i),
        .fu_exception_i (fu_exception_i),
        .fu_mispred_i   (fu_mispred_i),
        .lanes          (fu_lanes.producer)
    );

    load_result_align u_ld_align (
        .clock        (clock),
        .arst_n_i     (arst_n_i),
        .ld_valid_i   (ld_valid_i),
        .ld_ready_o   (ld_ready_o),
        .ld_data_i    (ld_data_i),
        .ld_addr_lo_i (ld_addr_lo_i),
        .ld_funct3_i  (ld_funct3_i),
        .ld_dest_i    (ld_dest_i),
        .ld_rob_idx_i (ld_rob_idx_i),
        .ld_drain_i   (ld_drain),
        .lane         (ld_lane.producer)
    );

    complete_merge #(
        .WB_WIDTH  (WB_WIDTH),
        .LOAD_LANE (LOAD_LANE)
    ) u_merge (
        .fu_lanes       (fu_lanes.consumer),
        .ld_lane        (ld_lane.consumer),
        .ld_drain_o     (ld_drain),
        .prf_wr_en_o    (prf_wr_en_o),
        .prf_waddr_o    (prf_waddr_o),
        .prf_wdata_o    (prf_wdata_o),
        .wb_valid_o     (wb_valid_o),
        .wb_rob_idx_o   (wb_rob_idx_o),
        .wb_exception_o (wb_exception_o),
        .wb_mispred_o   (wb_mispred_o),
        .wb_value_o     (wb_value_o),
        .cdb_o          (cdb_o)
    );

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    // reset held over 5 rising edges, released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

//--- test/complete_unit_properties.sv
module complete_unit_properties
    import wb_pkg::*;
#(
    parameter int unsigned WB_WIDTH  = 4,
    parameter int unsigned LOAD_LANE = 2
) (
    input logic                      clock_i,
    input logic                      arst_n_i,
    input logic       [WB_WIDTH-1:0] fu_valid_i,
    input prf_tag_t   [WB_WIDTH-1:0] fu_dest_i,
    input logic                      ld_drain_i,
    input logic                      ld_ready_i,
    input logic       [WB_WIDTH-1:0] prf_wr_en_i,
    input prf_tag_t   [WB_WIDTH-1:0] prf_waddr_i,
    input logic       [WB_WIDTH-1:0] wb_valid_i,
    input logic       [WB_WIDTH-1:0] wb_exception_i,
    input logic       [WB_WIDTH-1:0] wb_mispred_i,
    input cdb_entry_t [WB_WIDTH-1:0] cdb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // load buffer is empty coming out of reset
    ready_after_reset: assert property (@(posedge clock_i) $rose(arst_n_i) |-> ld_ready_i)
        else begin
            $error("ld_ready_o low right after reset release");
            fail_count++;
        end

    load_flags_clear: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        ld_drain_i |-> !wb_exception_i[LOAD_LANE] && !wb_mispred_i[LOAD_LANE])
        else begin
            $error("load written back with exception or mispredict set");
            fail_count++;
        end

    for (genvar i = 0; i < WB_WIDTH; i++) begin : g_lane
        valid_agree: assert property (@(posedge clock_i) disable iff (!arst_n_i)
            (prf_wr_en_i[i] == wb_valid_i[i]) && (cdb_i[i].valid == wb_valid_i[i]))
            else begin
                $error("lane %0d valid outputs disagree", i);
                fail_count++;
            end
        // result captured last cycle leaves with its own tag on both buses
        tag_match: assert property (@(posedge clock_i) disable iff (!arst_n_i)
            $past(fu_valid_i[i]) |-> wb_valid_i[i]
                && prf_waddr_i[i] == $past(fu_dest_i[i])
                && cdb_i[i].phys_tag == $past(fu_dest_i[i]))
            else begin
                $error("lane %0d register address or bus tag differs from the unit's tag", i);
                fail_count++;
            end
    end

endmodule

bind complete_unit complete_unit_properties #(
    .WB_WIDTH  (WB_WIDTH),
    .LOAD_LANE (LOAD_LANE)
) u_props (
    .clock_i        (clock),
    .arst_n_i       (arst_n_i),
    .fu_valid_i     (fu_valid_i),
    .fu_dest_i      (fu_dest_i),
    .ld_drain_i     (ld_drain),
    .ld_ready_i     (ld_ready_o),
    .prf_wr_en_i    (prf_wr_en_o),
    .prf_waddr_i    (prf_waddr_o),
    .wb_valid_i     (wb_valid_o),
    .wb_exception_i (wb_exception_o),
    .wb_mispred_i   (wb_mispred_o),
    .cdb_i          (cdb_o)
);

//--- test/tb_complete_unit.sv
module tb_complete_unit
    import isa_pkg::*;
    import wb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned WB_WIDTH    = 4;
    localparam int unsigned LOAD_LANE   = 2;
    localparam int unsigned SEED        = 32'h8c456958;
    localparam int unsigned TEST_CYCLES = 40; // 1 + 9 + 21 + 4 + 5 after reset
    localparam int unsigned MAX_CYCLES  = 2 * TEST_CYCLES;
    localparam logic [2:0]  LOAD_OPS [5] = '{LB, LH, LW, LBU, LHU};

    logic                      clock;
    logic                      arst_n_i;
    logic       [WB_WIDTH-1:0] fu_valid_i;
    xlen_t      [WB_WIDTH-1:0] fu_value_i;
    xlen_t      [WB_WIDTH-1:0] fu_link_i;
    logic       [WB_WIDTH-1:0] fu_is_jump_i;
    prf_tag_t   [WB_WIDTH-1:0] fu_dest_i;
    rob_idx_t   [WB_WIDTH-1:0] fu_rob_idx_i;
    logic       [WB_WIDTH-1:0] fu_exception_i;
    logic       [WB_WIDTH-1:0] fu_mispred_i;
    logic                      ld_valid_i;
    logic                      ld_ready_o;
    xlen_t                     ld_data_i;
    logic       [1:0]          ld_addr_lo_i;
    logic       [2:0]          ld_funct3_i;
    prf_tag_t                  ld_dest_i;
    rob_idx_t                  ld_rob_idx_i;
    logic       [WB_WIDTH-1:0] prf_wr_en_o;
    prf_tag_t   [WB_WIDTH-1:0] prf_waddr_o;
    xlen_t      [WB_WIDTH-1:0] prf_wdata_o;
    logic       [WB_WIDTH-1:0] wb_valid_o;
    rob_idx_t   [WB_WIDTH-1:0] wb_rob_idx_o;
    logic       [WB_WIDTH-1:0] wb_exception_o;
    logic       [WB_WIDTH-1:0] wb_mispred_o;
    xlen_t      [WB_WIDTH-1:0] wb_value_o;
    cdb_entry_t [WB_WIDTH-1:0] cdb_o;
    int unsigned               cycles = 0;
    int unsigned               errors = 0;

    tb_clock_gen u_clock_gen (.clk_o(clock), .arst_n_o(arst_n_i));

    complete_unit dut0 (.*);

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, tests did not finish", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // expected load value from the word zero-padded above bit 31
    function automatic xlen_t load_model(input xlen_t data, input logic [1:0] off,
                                         input logic [2:0] funct3);
        load_dec_t   dec;
        logic [63:0] wide;
        logic [7:0]  b;
        logic [15:0] h;
        dec  = load_decode(funct3);
        wide = {32'h0, data};
        b    = wide[8*off +: 8];
        h    = wide[8*off +: 16];
        case (dec.size)
            BYTE:    return dec.is_signed ? {{24{b[7]}}, b} : {24'h0, b};
            HALF:    return dec.is_signed ? {{16{h[15]}}, h} : {16'h0, h};
            default: return data;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input int lane,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %s[%0d] got %h exp %h", name, lane, got, exp);
        errors++;
    endtask

    task automatic check_prf(input int lane, input logic en, input prf_tag_t tag,
                             input xlen_t data);
        if (prf_wr_en_o[lane] !== en) begin
            report_mismatch("prf_wr_en_o", lane, prf_wr_en_o[lane], en);
        end else if (en) begin
            if (prf_waddr_o[lane] !== tag) begin
                report_mismatch("prf_waddr_o", lane, prf_waddr_o[lane], tag);
            end
            if (prf_wdata_o[lane] !== data) begin
                report_mismatch("prf_wdata_o", lane, prf_wdata_o[lane], data);
            end
        end
    endtask

    task automatic check_rob(input int lane, input logic vld, input rob_idx_t idx,
                             input logic exc, input logic mis, input xlen_t value);
        if (wb_valid_o[lane] !== vld) begin
            report_mismatch("wb_valid_o", lane, wb_valid_o[lane], vld);
        end else if (vld) begin
            if (wb_rob_idx_o[lane] !== idx) begin
                report_mismatch("wb_rob_idx_o", lane, wb_rob_idx_o[lane], idx);
            end
            if (wb_exception_o[lane] !== exc) begin
                report_mismatch("wb_exception_o", lane, wb_exception_o[lane], exc);
            end
            if (wb_mispred_o[lane] !== mis) begin
                report_mismatch("wb_mispred_o", lane, wb_mispred_o[lane], mis);
            end
            if (wb_value_o[lane] !== value) begin
                report_mismatch("wb_value_o", lane, wb_value_o[lane], value);
            end
        end
    endtask

    task automatic check_cdb(input int lane, input cdb_entry_t exp);
        if (cdb_o[lane].valid !== exp.valid) begin
            report_mismatch("cdb_o.valid", lane, cdb_o[lane].valid, exp.valid);
        end else if (exp.valid) begin
            if (cdb_o[lane].phys_tag !== exp.phys_tag) begin
                report_mismatch("cdb_o.phys_tag", lane, cdb_o[lane].phys_tag, exp.phys_tag);
            end
            if (cdb_o[lane].value !== exp.value) begin
                report_mismatch("cdb_o.value", lane, cdb_o[lane].value, exp.value);
            end
        end
    endtask

    task automatic check_ready(input logic exp);
        if (ld_ready_o !== exp) report_mismatch("ld_ready_o", 0, ld_ready_o, exp);
    endtask

    task automatic expect_lane(input int lane, input logic vld, input prf_tag_t tag,
                               input rob_idx_t idx, input logic exc, input logic mis,
                               input xlen_t value);
        cdb_entry_t exp_cdb;
        exp_cdb.valid    = vld;
        exp_cdb.phys_tag = tag;
        exp_cdb.value    = value;
        check_prf(lane, vld, tag, value);
        check_rob(lane, vld, idx, exc, mis, value);
        check_cdb(lane, exp_cdb);
    endtask

    task automatic expect_all_idle();
        for (int i = 0; i < WB_WIDTH; i++) expect_lane(i, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic clear_inputs();
        fu_valid_i     = '0;
        fu_value_i     = '0;
        fu_link_i      = '0;
        fu_is_jump_i   = '0;
        fu_dest_i      = '0;
        fu_rob_idx_i   = '0;
        fu_exception_i = '0;
        fu_mispred_i   = '0;
        ld_valid_i     = 1'b0;
        ld_data_i      = '0;
        ld_addr_lo_i   = '0;
        ld_funct3_i    = '0;
        ld_dest_i      = '0;
        ld_rob_idx_i   = '0;
    endtask

    task automatic drive_fu_lane(input int lane, input xlen_t value, input prf_tag_t tag,
                                 input rob_idx_t idx);
        fu_valid_i[lane]     = 1'b1;
        fu_value_i[lane]     = value;
        fu_is_jump_i[lane]   = 1'b0;
        fu_dest_i[lane]      = tag;
        fu_rob_idx_i[lane]   = idx;
        fu_exception_i[lane] = 1'b0;
        fu_mispred_i[lane]   = 1'b0;
    endtask

    // fresh random result on every lane
    task automatic randomize_fu_inputs();
        for (int i = 0; i < WB_WIDTH; i++) begin
            fu_valid_i[i]     = 1'b1;
            fu_value_i[i]     = $urandom;
            fu_link_i[i]      = $urandom;
            fu_is_jump_i[i]   = $urandom_range(1, 0);
            fu_dest_i[i]      = prf_tag_t'($urandom);
            fu_rob_idx_i[i]   = rob_idx_t'($urandom);
            fu_exception_i[i] = $urandom_range(1, 0);
            fu_mispred_i[i]   = $urandom_range(1, 0);
        end
    endtask

    // returns one falling edge after the load is taken with valid still high
    task automatic send_load(input xlen_t data, input logic [1:0] off, input logic [2:0] funct3,
                             input prf_tag_t tag, input rob_idx_t idx);
        ld_valid_i   = 1'b1;
        ld_data_i    = data;
        ld_addr_lo_i = off;
        ld_funct3_i  = funct3;
        ld_dest_i    = tag;
        ld_rob_idx_i = idx;
        while (!ld_ready_o) @(negedge clock);
        @(negedge clock);
    endtask

    task automatic test_reset_idle();
        expect_all_idle();
        check_ready(1'b1);
    endtask

    task automatic test_fu_lanes();
        prf_tag_t exp_tag [WB_WIDTH];
        rob_idx_t exp_idx [WB_WIDTH];
        logic     exp_exc [WB_WIDTH];
        logic     exp_mis [WB_WIDTH];
        xlen_t    exp_val [WB_WIDTH];
        randomize_fu_inputs();
        for (int n = 0; n < 8; n++) begin
            for (int i = 0; i < WB_WIDTH; i++) begin
                exp_tag[i] = fu_dest_i[i];
                exp_idx[i] = fu_rob_idx_i[i];
                exp_exc[i] = fu_exception_i[i];
                exp_mis[i] = fu_mispred_i[i];
                exp_val[i] = fu_is_jump_i[i] ? fu_link_i[i] : fu_value_i[i]; // link for jumps
            end
            @(negedge clock);
            // next results go in before the check
            if (n < 7) begin
                randomize_fu_inputs();
            end else begin
                fu_valid_i = '0;
            end
            for (int i = 0; i < WB_WIDTH; i++) begin
                expect_lane(i, 1'b1, exp_tag[i], exp_idx[i], exp_exc[i], exp_mis[i],
                            exp_val[i]);
            end
        end
        @(negedge clock);
        expect_all_idle();
    endtask

    task automatic test_load_align();
        xlen_t    data;
        prf_tag_t tag;
        rob_idx_t idx;
        for (int f = 0; f < 5; f++) begin
            for (int off = 0; off < 4; off++) begin
                data = $urandom;
                tag  = prf_tag_t'($urandom);
                idx  = rob_idx_t'($urandom);
                send_load(data, 2'(off), LOAD_OPS[f], tag, idx);
                ld_data_i = ~data; // bus moves on, held result must not
                expect_lane(LOAD_LANE, 1'b1, tag, idx, 1'b0, 1'b0,
                            load_model(data, 2'(off), LOAD_OPS[f]));
            end
        end
        ld_valid_i = 1'b0;
        @(negedge clock);
        expect_all_idle();
    endtask

    task automatic test_lane_conflict();
        xlen_t    val_a;
        xlen_t    val_b;
        xlen_t    ld_data;
        int       waited;
        val_a   = $urandom;
        val_b   = $urandom;
        ld_data = $urandom;
        waited  = 0;
        drive_fu_lane(LOAD_LANE, val_a, 7'h21, 6'h11);
        send_load(ld_data, 2'd0, LW, 7'h23, 6'h13); // taken on the same edge as A
        ld_valid_i = 1'b0;
        expect_lane(LOAD_LANE, 1'b1, 7'h21, 6'h11, 1'b0, 1'b0, val_a);
        check_ready(1'b0);
        drive_fu_lane(LOAD_LANE, val_b, 7'h22, 6'h12);
        @(negedge clock);
        expect_lane(LOAD_LANE, 1'b1, 7'h22, 6'h12, 1'b0, 1'b0, val_b);
        check_ready(1'b0);
        fu_valid_i = '0;
        do begin
            @(negedge clock);
            waited++;
        end while (!(wb_valid_o[LOAD_LANE] && wb_rob_idx_o[LOAD_LANE] == 6'h13));
        if (waited != 1) begin
            $display("held load came out %0d cycles after the shared lane went idle", waited);
            errors++;
        end
        expect_lane(LOAD_LANE, 1'b1, 7'h23, 6'h13, 1'b0, 1'b0, ld_data);
        check_ready(1'b1);
        @(negedge clock);
        expect_all_idle();
    endtask

    task automatic test_back_to_back();
        xlen_t       data;
        logic [1:0]  off;
        logic [2:0]  op;
        int unsigned start;
        start = cycles;
        for (int k = 0; k < 4; k++) begin
            data = $urandom;
            off  = 2'($urandom);
            op   = LOAD_OPS[$urandom_range(4, 0)];
            send_load(data, off, op, prf_tag_t'(7'h40 + k), rob_idx_t'(6'h30 + k));
            expect_lane(LOAD_LANE, 1'b1, prf_tag_t'(7'h40 + k), rob_idx_t'(6'h30 + k),
                        1'b0, 1'b0, load_model(data, off, op));
            check_ready(1'b1);
        end
        if (cycles - start != 4) begin
            $display("4 back-to-back loads took %0d cycles instead of 4", cycles - start);
            errors++;
        end
        ld_valid_i = 1'b0;
        @(negedge clock);
        expect_all_idle();
    endtask

    initial begin
        void'($urandom(SEED));
        clear_inputs();
        @(posedge arst_n_i);
        @(negedge clock);
        test_reset_idle();
        test_fu_lanes();
        test_load_align();
        test_lane_conflict();
        test_back_to_back();
        $display("checks done, %0d compare errors, %0d assertion failures",
                 errors, dut0.u_props.fail_count);
        if (errors == 0 && dut0.u_props.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/isa_pkg.sv
design/wb_pkg.sv
design/wb_lane_if.sv
design/fu_result_capture.sv
design/load_result_align.sv
design/complete_merge.sv
design/complete_unit.sv
test/tb_clock_gen.sv
test/complete_unit_properties.sv
test/tb_complete_unit.sv

//--- Bender.yml
package:
  name: complete_unit

sources:
  - files:
      - design/isa_pkg.sv
      - design/wb_pkg.sv
      - design/wb_lane_if.sv
      - design/fu_result_capture.sv
      - design/load_result_align.sv
      - design/complete_merge.sv
      - design/complete_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/complete_unit_properties.sv
      - test/tb_complete_unit.sv
